/* hdl/buffer_pkg.sv */
// Buffer sizing constants
// Byte width of every data path
// Default and largest FIFO depth

package buffer_pkg;

  // Whole design moves bytes
  localparam int BYTE_W = 8;  // Data bits per entry

  // FIFO depth defaults
  localparam int DEPTH_DEFAULT = 13;  // Depth used by the top level
  localparam int DEPTH_MAX     = 16;  // Upper bound checked in the FIFO

  // Pointer width that covers the largest FIFO
  localparam int PTR_W_MAX = $clog2(DEPTH_MAX);  // 4 bits for 16 entries

  // Count width for the largest FIFO, needs one extra value for full
  localparam int CNT_W_MAX = $clog2(DEPTH_MAX + 1);  // 5 bits

endpackage : buffer_pkg

/* hdl/merge_pkg.sv */
// Stream merger types
// Arbitration mode opcodes
// Last-served state and output channel tag

package merge_pkg;

  // Arbitration opcode on the mode input
  typedef enum logic [1:0] {
    MODE_ROUND_ROBIN = 2'd0,  // Alternate when both have data
    MODE_A_FIRST     = 2'd1,  // A always wins
    MODE_B_FIRST     = 2'd2,  // B always wins
    MODE_HOLD        = 2'd3   // No pops at all
  } merge_mode_e;

  // Channel served by the last grant
  typedef enum logic {
    LAST_A = 1'b0,
    LAST_B = 1'b1   // Reset value, so A goes first
  } merger_state_e;

  // Source tag carried with each output byte
  typedef enum logic {
    CHAN_A = 1'b0,
    CHAN_B = 1'b1
  } chan_tag_e;

endpackage : merge_pkg

/* hdl/byte_fifo.sv */
// Byte FIFO on a circular buffer
// Full and empty flags from an occupancy count
// Sticky overflow flag for pushes dropped while full
// Registered read port loaded on pop

module byte_fifo #(
  parameter int DEPTH = buffer_pkg::DEPTH_DEFAULT  // Number of entries
) (
  input  logic                          rd_en,     // Clock
  input  logic                          wr_en,     // Async reset, active high
  input  logic                          push,      // Write strobe
  input  logic                          pop,       // Read strobe
  input  logic [buffer_pkg::BYTE_W-1:0] wr_data,   // Byte to store
  output logic [buffer_pkg::BYTE_W-1:0] rd_data,   // Oldest byte after a pop
  output logic                          full,      // Count at DEPTH
  output logic                          empty,     // Count at zero
  output logic                          overflow   // Sticky, set on dropped push
);

  localparam int PTR_W = $clog2(DEPTH);      // Pointer bits
  localparam int CNT_W = $clog2(DEPTH + 1);  // Count bits, holds DEPTH itself

  logic [buffer_pkg::BYTE_W-1:0] mem [DEPTH];  // Storage array
  logic [PTR_W-1:0]              wr_ptr;       // Next slot to write
  logic [PTR_W-1:0]              rd_ptr;       // Oldest entry
  logic [CNT_W-1:0]              count;        // Entries held
  logic                          wr_ok;        // Push accepted
  logic                          rd_ok;        // Pop accepted

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // A push while full is dropped even with a pop in the same cycle
  assign wr_ok = push && !full;
  assign rd_ok = pop && !empty;

  // Storage, written only on an accepted push
  always_ff @(posedge rd_en) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers, count, read register and overflow
  always_ff @(posedge rd_en or posedge wr_en) begin
    if (wr_en) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_data  <= '0;                 // Merged output reads 0 after reset
      overflow <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at DEPTH
      end
      if (rd_ok) begin
        rd_data <= mem[rd_ptr];       // Oldest byte out
        rd_ptr  <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;  // Push only
        2'b01:   count <= count - 1'b1;  // Pop only
        default: count <= count;         // Both or neither
      endcase
      if (push && full) begin
        overflow <= 1'b1;             // Held until reset
      end
    end
  end

  // The merger must never pop an empty FIFO
  a_no_pop_empty : assert property (
    @(posedge rd_en) disable iff (wr_en) pop |-> !empty
  ) else $error("byte_fifo pop while empty");

  // Occupancy stays within the array
  a_count_bound : assert property (
    @(posedge rd_en) disable iff (wr_en) count <= CNT_W'(DEPTH)
  ) else $error("byte_fifo count above DEPTH");

  // Depth set by the top level must be legal
  a_depth_range : assert property (
    @(posedge rd_en) (DEPTH >= 2) && (DEPTH <= buffer_pkg::DEPTH_MAX)
  ) else $error("byte_fifo DEPTH outside 2 to DEPTH_MAX");

endmodule : byte_fifo

/* hdl/stream_merger.sv */
// Two-channel stream merger
// Combinational pop grant by arbitration mode
// Last-served register for round robin
// Tagged output byte with a one-cycle valid pulse

module stream_merger (
  input  logic                          rd_en,      // Clock
  input  logic                          wr_en,      // Async reset, active high
  input  logic                          drain,      // Level, output enabled
  input  merge_pkg::merge_mode_e        mode,       // Arbitration opcode
  input  logic                          empty_a,    // FIFO A empty
  input  logic                          empty_b,    // FIFO B empty
  input  logic [buffer_pkg::BYTE_W-1:0] data_a,     // FIFO A read register
  input  logic [buffer_pkg::BYTE_W-1:0] data_b,     // FIFO B read register
  output logic                          pop_a,      // Pop strobe to FIFO A
  output logic                          pop_b,      // Pop strobe to FIFO B
  output logic                          out_valid,  // One-cycle pulse per byte
  output logic [buffer_pkg::BYTE_W-1:0] out_data,   // Selected byte
  output merge_pkg::chan_tag_e          out_chan    // Source of out_data
);

  merge_pkg::merger_state_e last_q;  // Channel granted last
  logic                     go;       // Draining allowed this cycle
  logic                     pick_a;   // A would win
  logic                     pick_b;   // B would win
  logic                     has_a;    // A holds data
  logic                     has_b;    // B holds data

  assign has_a = !empty_a;
  assign has_b = !empty_b;
  assign go    = drain && (mode != merge_pkg::MODE_HOLD);

  // Winner selection, at most one side
  always_comb begin
    pick_a = 1'b0;
    pick_b = 1'b0;
    unique case (mode)
      merge_pkg::MODE_A_FIRST: begin
        pick_a = has_a;               // A whenever it has data
        pick_b = has_b && !has_a;
      end
      merge_pkg::MODE_B_FIRST: begin
        pick_b = has_b;               // B whenever it has data
        pick_a = has_a && !has_b;
      end
      merge_pkg::MODE_ROUND_ROBIN: begin
        if (has_a && has_b) begin
          pick_a = (last_q == merge_pkg::LAST_B);  // Other side of last grant
          pick_b = (last_q == merge_pkg::LAST_A);
        end else begin
          pick_a = has_a;             // Lone channel wins
          pick_b = has_b;
        end
      end
      merge_pkg::MODE_HOLD: begin
        pick_a = 1'b0;                // Nothing drains
        pick_b = 1'b0;
      end
      default: begin
        pick_a = 1'b0;
        pick_b = 1'b0;
      end
    endcase
  end

  // Pops go straight out, never to an empty side
  assign pop_a = go && pick_a;
  assign pop_b = go && pick_b;

  // Grant history, tag and valid pulse
  always_ff @(posedge rd_en or posedge wr_en) begin
    if (wr_en) begin
      last_q    <= merge_pkg::LAST_B;  // Round robin starts on A
      out_valid <= 1'b0;
      out_chan  <= merge_pkg::CHAN_A;
    end else begin
      out_valid <= pop_a || pop_b;     // Byte lands in rd_data this edge
      if (pop_a) begin
        last_q   <= merge_pkg::LAST_A;
        out_chan <= merge_pkg::CHAN_A;
      end else if (pop_b) begin
        last_q   <= merge_pkg::LAST_B;
        out_chan <= merge_pkg::CHAN_B;
      end
    end
  end

  // Read registers already hold the popped byte, pick by tag
  assign out_data = (out_chan == merge_pkg::CHAN_B) ? data_b : data_a;

  // Only one FIFO drains per cycle
  a_one_pop : assert property (
    @(posedge rd_en) disable iff (wr_en) !(pop_a && pop_b)
  ) else $error("stream_merger popped both channels");

endmodule : stream_merger

/* hdl/dual_byte_buffer.sv */
// Dual-channel byte receive buffer
// Two byte FIFOs, one per producer
// Merger producing one tagged output stream

module dual_byte_buffer #(
  parameter int DEPTH = buffer_pkg::DEPTH_DEFAULT  // Entries per FIFO
) (
  input  logic                          rd_en,       // Clock
  input  logic                          wr_en,       // Async reset, active high
  input  logic                          push_a,      // Channel A write strobe
  input  logic [buffer_pkg::BYTE_W-1:0] data_a,      // Channel A byte
  input  logic                          push_b,      // Channel B write strobe
  input  logic [buffer_pkg::BYTE_W-1:0] data_b,      // Channel B byte
  input  logic                          drain,       // Output enable level
  input  merge_pkg::merge_mode_e        mode,        // Arbitration opcode
  output logic                          out_valid,   // Byte pulse
  output logic [buffer_pkg::BYTE_W-1:0] out_data,    // Merged byte
  output merge_pkg::chan_tag_e          out_chan,    // Byte source
  output logic                          full_a,
  output logic                          full_b,
  output logic                          empty_a,
  output logic                          empty_b,
  output logic                          overflow_a,  // Sticky drop flag A
  output logic                          overflow_b   // Sticky drop flag B
);

  logic                          pop_a;   // Merger to FIFO A
  logic                          pop_b;   // Merger to FIFO B
  logic [buffer_pkg::BYTE_W-1:0] rdata_a; // FIFO A read register
  logic [buffer_pkg::BYTE_W-1:0] rdata_b; // FIFO B read register

  byte_fifo #(.DEPTH(DEPTH)) u_fifo_a (
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .push     (push_a),
    .pop      (pop_a),
    .wr_data  (data_a),
    .rd_data  (rdata_a),
    .full     (full_a),
    .empty    (empty_a),
    .overflow (overflow_a)
  );

  byte_fifo #(.DEPTH(DEPTH)) u_fifo_b (
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .push     (push_b),
    .pop      (pop_b),
    .wr_data  (data_b),
    .rd_data  (rdata_b),
    .full     (full_b),
    .empty    (empty_b),
    .overflow (overflow_b)
  );

  stream_merger u_merger (
    .rd_en     (rd_en),
    .wr_en     (wr_en),
    .drain     (drain),
    .mode      (mode),
    .empty_a   (empty_a),
    .empty_b   (empty_b),
    .data_a    (rdata_a),
    .data_b    (rdata_b),
    .pop_a     (pop_a),
    .pop_b     (pop_b),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_chan  (out_chan)
  );

endmodule : dual_byte_buffer

/* testbench/tb_clock_gen.sv */
// Clock and reset source for the testbench
// 40 ns clock, reset held high for the first 10 rising edges

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,  // Clock period
  parameter int RESET_CYCLES = 10   // Rising edges under reset
) (
  output logic rd_en,  // Clock
  output logic wr_en   // Reset, active high
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    rd_en = 1'b0;
    forever #(PERIOD_NS / 2) rd_en = ~rd_en;
  end

  initial begin
    wr_en = 1'b1;
    repeat (RESET_CYCLES) @(posedge rd_en);
    wr_en <= 1'b0;  // Release on a rising edge
  end
endmodule : tb_clock_gen

/* testbench/tb_dual_byte_buffer.sv */
// Testbench for the dual-channel byte buffer
// Reads cycles, phase markers and check markers from the stim file
// Queue model per channel predicts each output byte, tag and flag

module tb_dual_byte_buffer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    DEPTH     = 13;                                    // Same as the DUT
  localparam string STIM_FILE = "testbench/dual_byte_buffer_stim.txt";

  logic rd_en, wr_en, push_a, push_b, drain, out_valid;
  logic full_a, full_b, empty_a, empty_b, overflow_a, overflow_b;
  logic [7:0] data_a, data_b, out_data;
  merge_pkg::merge_mode_e mode;
  merge_pkg::chan_tag_e   out_chan;

  logic [7:0] q_a[$];                 // Bytes held in FIFO A
  logic [7:0] q_b[$];                 // Bytes held in FIFO B
  logic ovf_a, ovf_b;                 // Expected sticky flags
  int tot_a, tot_b;                   // Bytes out per channel
  merge_pkg::chan_tag_e last_chan;    // Channel served last
  logic pv_pa, pv_pb, pv_dr;          // Inputs taken at the last edge
  logic [7:0] pv_da, pv_db;
  merge_pkg::merge_mode_e pv_md;
  string stim_lines[$];
  longint watch_ns;                   // Zero until the stim is loaded

  tb_clock_gen u_clock_gen (.rd_en(rd_en), .wr_en(wr_en));

  dual_byte_buffer #(.DEPTH(DEPTH)) i_dual_byte_buffer (
    .rd_en(rd_en), .wr_en(wr_en), .push_a(push_a), .data_a(data_a), .push_b(push_b),
    .data_b(data_b), .drain(drain), .mode(mode), .out_valid(out_valid),
    .out_data(out_data), .out_chan(out_chan), .full_a(full_a), .full_b(full_b),
    .empty_a(empty_a), .empty_b(empty_b), .overflow_a(overflow_a), .overflow_b(overflow_b)
  );

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  // Outputs after an edge, against the queues as they were before it
  task automatic check_cycle();
    int size_a, size_b;
    logic exp_valid;
    merge_pkg::chan_tag_e exp_chan;
    logic [7:0] head;
    size_a    = q_a.size();
    size_b    = q_b.size();
    exp_valid = pv_dr && (pv_md != merge_pkg::MODE_HOLD) && (size_a + size_b != 0);
    if (size_a != 0 && size_b != 0) begin
      if (pv_md == merge_pkg::MODE_A_FIRST) exp_chan = merge_pkg::CHAN_A;
      else if (pv_md == merge_pkg::MODE_B_FIRST) exp_chan = merge_pkg::CHAN_B;
      else exp_chan = (last_chan == merge_pkg::CHAN_A) ? merge_pkg::CHAN_B : merge_pkg::CHAN_A;
    end else begin
      exp_chan = (size_a != 0) ? merge_pkg::CHAN_A : merge_pkg::CHAN_B;  // Lone channel
    end
    assert (out_valid == exp_valid)
      else value_error($sformatf("out_valid %b, expected %b", out_valid, exp_valid));
    if (exp_valid) begin
      assert (out_chan == exp_chan)
        else value_error($sformatf("out_chan %s, expected %s", out_chan.name(), exp_chan.name()));
      if (exp_chan == merge_pkg::CHAN_A) head = q_a.pop_front();
      else head = q_b.pop_front();
      assert (out_data == head)
        else value_error($sformatf("out_data %h, expected %h", out_data, head));
      if (exp_chan == merge_pkg::CHAN_A) tot_a++;
      else tot_b++;
      last_chan = exp_chan;
    end
    // Full is judged before the edge, a pop in the same cycle does not help
    if (pv_pa && size_a < DEPTH) q_a.push_back(pv_da);
    if (pv_pa && size_a == DEPTH) ovf_a = 1'b1;
    if (pv_pb && size_b < DEPTH) q_b.push_back(pv_db);
    if (pv_pb && size_b == DEPTH) ovf_b = 1'b1;
    assert ({full_a, empty_a, overflow_a} == {q_a.size() == DEPTH, q_a.size() == 0, ovf_a})
      else value_error($sformatf("A flags full/empty/ovf %b%b%b", full_a, empty_a, overflow_a));
    assert ({full_b, empty_b, overflow_b} == {q_b.size() == DEPTH, q_b.size() == 0, ovf_b})
      else value_error($sformatf("B flags full/empty/ovf %b%b%b", full_b, empty_b, overflow_b));
  endtask

  task automatic drive_cycle(input logic pa, input logic [7:0] da, input logic pb,
                             input logic [7:0] db, input logic dr,
                             input merge_pkg::merge_mode_e md);
    @(posedge rd_en);
    push_a <= pa;
    data_a <= da;
    push_b <= pb;
    data_b <= db;
    drain  <= dr;
    mode   <= md;
    @(negedge rd_en);
    check_cycle();                    // Looks at the previous inputs
    pv_pa = pa;
    pv_da = da;
    pv_pb = pb;
    pv_db = db;
    pv_dr = dr;
    pv_md = md;
  endtask

  task automatic run_line(input string line);
    int rep, pa, da, pb, db, dr, md, ova, ovb, ta, tb;
    if ($sscanf(line, "c %d %d %h %d %h %d %d", rep, pa, da, pb, db, dr, md) == 7) begin
      for (int i = 0; i < rep; i++) begin  // Data steps by one per repeat
        drive_cycle(pa[0], 8'(da + i), pb[0], 8'(db + i), dr[0], merge_pkg::merge_mode_e'(md));
      end
    end else if ($sscanf(line, "k %d %d %d %d", ova, ovb, ta, tb) == 4) begin
      assert (overflow_a == ova[0] && overflow_b == ovb[0])
        else value_error($sformatf("overflow %b%b, marker %0d%0d", overflow_a, overflow_b,
                                   ova, ovb));
      assert (tot_a == ta && tot_b == tb)
        else value_error($sformatf("totals %0d/%0d, marker %0d/%0d", tot_a, tot_b, ta, tb));
    end else if ($sscanf(line, "p %d", rep) == 1) begin
      $display("phase %0d at %0t ns", rep, $time);
    end else begin
      stop_run({"stim file holds a line that cannot be read: ", line});
    end
  endtask

  initial begin
    wait (watch_ns != 0);
    #(watch_ns);
    stop_run("watchdog expired, the run did not finish in time");
  end

  initial begin
    int fd, cycles, rep;
    string line;
    {push_a, push_b, drain, data_a, data_b} = '0;
    mode = merge_pkg::MODE_ROUND_ROBIN;
    {pv_pa, pv_pb, pv_dr, pv_da, pv_db, ovf_a, ovf_b} = '0;
    pv_md     = merge_pkg::MODE_ROUND_ROBIN;
    last_chan = merge_pkg::CHAN_B;          // Round robin opens on A
    {tot_a, tot_b, cycles} = '0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) stop_run("the stim file could not be opened");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") stim_lines.push_back(line);
      if ($sscanf(line, "c %d", rep) == 1) cycles += rep;
    end
    $fclose(fd);
    watch_ns = longint'(cycles + 10 + 40) * 40 * 2;
    @(negedge wr_en);
    @(negedge rd_en);
    assert (!out_valid && empty_a && empty_b && !full_a && !full_b && !overflow_a && !overflow_b)
      else value_error("outputs not at their reset values");
    foreach (stim_lines[i]) run_line(stim_lines[i]);
    do begin
      drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, merge_pkg::MODE_ROUND_ROBIN);
    end while (q_a.size() != 0 || q_b.size() != 0);
    $display("TEST PASS");
    $finish;
  end
endmodule : tb_dual_byte_buffer

/* testbench/dual_byte_buffer_stim.txt */
# c rep push_a data_a push_b data_b drain mode : one cycle, rep times, data +1 per repeat
# k ovf_a ovf_b total_a total_b : check marker ; p n : phase marker ; mode 0 rr 1 a 2 b 3 hold
p 1
c 2 0 00 0 00 0 0
k 0 0 0 0
p 2
c 5 1 10 0 00 1 0
c 4 0 00 0 00 1 0
k 0 0 5 0
p 3
c 15 1 20 0 00 0 0
c 2 0 00 0 00 0 0
k 1 0 5 0
c 16 0 00 0 00 1 0
k 1 0 18 0
p 4
c 4 1 40 1 80 0 1
c 10 0 00 0 00 1 1
k 1 0 22 4
c 4 1 50 1 90 0 2
c 10 0 00 0 00 1 2
k 1 0 26 8
p 5
c 3 1 60 1 a0 0 0
c 2 1 63 0 00 0 0
c 10 0 00 0 00 1 0
k 1 0 31 11
p 6
c 3 1 70 1 b0 1 3
c 2 0 00 0 00 1 3
k 1 0 31 11
c 12 1 c0 1 d0 1 0
c 22 0 00 0 00 1 0
k 1 0 46 26

/* all.f */
hdl/buffer_pkg.sv
hdl/merge_pkg.sv
hdl/byte_fifo.sv
hdl/stream_merger.sv
hdl/dual_byte_buffer.sv
testbench/tb_clock_gen.sv
testbench/tb_dual_byte_buffer.sv
